//--- tests/id_stage_stim.txt
// tag pc inst rs_data rt_data ex_ctl ex_data mem_ctl mem_data flags comb baddr ctl link rs rt
// ex_ctl {m2r[12],we[8],addr}, flags {rand_rt[8],rand_rs[4],ds[0]}, ctl {aluop,we,m2r,ram,ds,addr}
61646475 400 00221821 11 22 0 0 0 0 0 0 0 06100003 0 11 22
7375625f 400 00c72822 0 0 110 dead 111 beef 110 0 0 07100005 0 0 0
736c6c5f 404 000520c0 77 9 0 0 0 0 0 0 0 0b100004 0 0 9
62616473 408 002520c0 77 9 0 0 0 0 0 0 0 00000000 0 0 0
73726176 40c 01073007 4 80000000 0 0 0 0 0 0 0 10100006 0 4 80000000
61646469 410 2029fffc 100 55 0 0 0 0 0 0 0 14100009 0 100 0
6c75695f 414 3c0b1234 9 8 0 0 0 0 0 0 0 1810000b 0 0 0
6c775f5f 418 8fac0008 1000 66 0 0 0 0 0 0 0 1911000c 0 1000 0
73775f5f 41c afad0004 1000 44 0 0 0 0 0 0 0 1a001000 0 1000 44
696e765f 420 fc000000 1 2 0 0 0 0 0 0 0 00000000 0 0 0
66776578 424 00221820 11 22 101 aaaa 101 bbbb 0 0 0 05100003 0 aaaa 22
66776d6d 428 00221820 11 22 102 cccc 101 bbbb 0 0 0 05100003 0 bbbb cccc
66776e72 42c 000520c0 77 9 100 1234 0 0 0 0 0 0b100004 0 0 9
6c647573 430 00221821 11 22 1101 dead 0 0 0 1 0 00000000 0 0 0
6c647274 434 afad0004 1000 44 110d dead 0 0 0 1 0 00000000 0 0 0
6c646e72 438 8fac0008 1000 66 110c dead 0 0 0 0 0 1911000c 0 1000 0
62657174 400 10220004 5 5 0 0 0 0 0 110 414 1b000000 0 5 5
626e656e 400 1422fffe 5 5 0 0 0 0 0 100 0 1c000000 0 5 5
6267747a 400 1c600008 0 3 0 0 0 0 0 100 0 1d000000 0 0 0
626c657a 400 18600008 0 3 0 0 0 0 0 110 424 1e000000 0 0 0
626c747a 400 04800003 80000000 0 0 0 0 0 0 110 410 20000000 0 80000000 0
6267657a 400 04810003 80000000 0 0 0 0 0 0 100 0 1f000000 0 80000000 0
6267616c 400 04910003 7 0 0 0 0 0 1 110 410 2110011f 408 7 0
626c616c 400 04900003 7 0 0 0 0 0 0 100 0 2210001f 408 7 0
6a5f5f5f 10000400 08000100 0 0 0 0 0 0 0 110 10000400 23000000 0 0 0
6a616c5f 400 0c000040 0 0 0 0 0 0 1 110 100 2410011f 408 0 0
6a725f5f 400 03e00008 2000 0 11f 3000 0 0 0 110 3000 25000000 0 3000 0
6a616c72 400 00a01009 5000 0 0 0 0 0 0 110 5000 26100002 408 5000 0
6a727374 400 03e00008 2000 0 111f 3000 0 0 0 101 0 00000000 0 0 0

//--- project.f
hw/id_pkg.sv
hw/id_ctrl_if.sv
hw/inst_decoder.sv
hw/operand_select.sv
hw/branch_unit.sv
hw/id_ex_reg.sv
hw/id_stage.sv
tests/id_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ID stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module id_stage_tb \
    -Mdir obj_dir -o id_stage_sim -f project.f > build.log 2>&1 \
    && ./obj_dir/id_stage_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

//--- tests/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;

    localparam int          NUM_VEC      = 29;
    localparam int          VEC_WORDS    = 16;
    localparam int          RESET_CYCLES = 10;
    localparam int          TIMEOUT_NS   = (NUM_VEC + 20) * 40;
    localparam logic [31:0] SEED         = 32'h4f50_03b1;
    localparam logic [7:0]  NOP_CODE     = 8'h00;

    logic           clk;
    logic           reset_i;
    logic [31:0]    pc_i;
    logic [31:0]    inst_i;
    logic [31:0]    rs_data_i;
    logic [31:0]    rt_data_i;
    logic           ex_wr_en_i;
    logic [4:0]     ex_wr_addr_i;
    logic [31:0]    ex_wr_data_i;
    logic           ex_mem_to_reg_i;
    logic           mem_wr_en_i;
    logic [4:0]     mem_wr_addr_i;
    logic [31:0]    mem_wr_data_i;
    logic           now_in_delayslot_i;
    logic [31:0]    ex_pc_o;
    logic [7:0]     ex_aluop_o;
    logic [31:0]    ex_rs_data_o;
    logic [31:0]    ex_rt_data_o;
    logic [15:0]    ex_imm16_o;
    logic           ex_wr_en_o;
    logic [4:0]     ex_wr_addr_o;
    logic           ex_mem_to_reg_o;
    logic           ex_ram_we_o;
    logic [31:0]    ex_link_addr_o;
    logic           ex_in_delayslot_o;
    logic           stall_o;
    logic           branch_enable_o;
    logic [31:0]    branch_addr_o;
    logic           next_in_delayslot_o;

    logic [31:0]    stim [0:NUM_VEC*VEC_WORDS-1];
    logic [31:0]    rs_exp [0:NUM_VEC-1];
    logic [31:0]    rt_exp [0:NUM_VEC-1];
    int             errors;
    bit             stim_ok;

    id_stage uut (
        .clk(clk), .reset_i(reset_i), .pc_i(pc_i), .inst_i(inst_i),
        .rs_data_i(rs_data_i), .rt_data_i(rt_data_i),
        .ex_wr_en_i(ex_wr_en_i), .ex_wr_addr_i(ex_wr_addr_i),
        .ex_wr_data_i(ex_wr_data_i), .ex_mem_to_reg_i(ex_mem_to_reg_i),
        .mem_wr_en_i(mem_wr_en_i), .mem_wr_addr_i(mem_wr_addr_i),
        .mem_wr_data_i(mem_wr_data_i), .now_in_delayslot_i(now_in_delayslot_i),
        .ex_pc_o(ex_pc_o), .ex_aluop_o(ex_aluop_o), .ex_rs_data_o(ex_rs_data_o),
        .ex_rt_data_o(ex_rt_data_o), .ex_imm16_o(ex_imm16_o), .ex_wr_en_o(ex_wr_en_o),
        .ex_wr_addr_o(ex_wr_addr_o), .ex_mem_to_reg_o(ex_mem_to_reg_o),
        .ex_ram_we_o(ex_ram_we_o), .ex_link_addr_o(ex_link_addr_o),
        .ex_in_delayslot_o(ex_in_delayslot_o), .stall_o(stall_o),
        .branch_enable_o(branch_enable_o), .branch_addr_o(branch_addr_o),
        .next_in_delayslot_o(next_in_delayslot_o)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] stim_word(input int v, input int idx);
        return stim[v*VEC_WORDS + idx];
    endfunction

    // tag word holds four ascii characters
    function automatic string tag_name(input int v);
        return $sformatf("%s", stim_word(v, 0));
    endfunction

    task automatic report_mismatch(input string tag, input string field,
                                   input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("MISMATCH %s %s: expected %h, actual %h", tag, field, exp, act);
    endtask

    // ####################
    // driving
    // ####################
    task automatic drive_vector(input int v);
        logic [31:0] ex_ctl;
        logic [31:0] mem_ctl;
        logic [31:0] flags;
        ex_ctl    = stim_word(v, 5);
        mem_ctl   = stim_word(v, 7);
        flags     = stim_word(v, 9);
        rs_exp[v] = stim_word(v, 14);
        rt_exp[v] = stim_word(v, 15);
        // register file data drawn at random where the vector flags it
        if (flags[4])
            rs_exp[v] = $urandom;
        if (flags[8])
            rt_exp[v] = $urandom;
        pc_i               <= stim_word(v, 1);
        inst_i             <= stim_word(v, 2);
        rs_data_i          <= flags[4] ? rs_exp[v] : stim_word(v, 3);
        rt_data_i          <= flags[8] ? rt_exp[v] : stim_word(v, 4);
        ex_mem_to_reg_i    <= ex_ctl[12];
        ex_wr_en_i         <= ex_ctl[8];
        ex_wr_addr_i       <= ex_ctl[4:0];
        ex_wr_data_i       <= stim_word(v, 6);
        mem_wr_en_i        <= mem_ctl[8];
        mem_wr_addr_i      <= mem_ctl[4:0];
        mem_wr_data_i      <= stim_word(v, 8);
        now_in_delayslot_i <= flags[0];
    endtask

    task automatic drive_idle();
        pc_i               <= '0;
        inst_i             <= '0;
        rs_data_i          <= '0;
        rt_data_i          <= '0;
        ex_mem_to_reg_i    <= 1'b0;
        ex_wr_en_i         <= 1'b0;
        ex_wr_addr_i       <= '0;
        ex_wr_data_i       <= '0;
        mem_wr_en_i        <= 1'b0;
        mem_wr_addr_i      <= '0;
        mem_wr_data_i      <= '0;
        now_in_delayslot_i <= 1'b0;
    endtask

    // ####################
    // checking
    // ####################
    task automatic check_reset_state();
        if (ex_wr_en_o !== 1'b0)
            report_mismatch("reset", "ex_wr_en", 32'h0, 32'(ex_wr_en_o));
        if (ex_mem_to_reg_o !== 1'b0)
            report_mismatch("reset", "ex_mem_to_reg", 32'h0, 32'(ex_mem_to_reg_o));
        if (ex_ram_we_o !== 1'b0)
            report_mismatch("reset", "ex_ram_we", 32'h0, 32'(ex_ram_we_o));
        if (ex_in_delayslot_o !== 1'b0)
            report_mismatch("reset", "ex_in_delayslot", 32'h0, 32'(ex_in_delayslot_o));
        if (ex_aluop_o !== NOP_CODE)
            report_mismatch("reset", "ex_aluop", 32'(NOP_CODE), 32'(ex_aluop_o));
        if (branch_enable_o !== 1'b0)
            report_mismatch("reset", "branch_enable", 32'h0, 32'(branch_enable_o));
    endtask

    // same cycle outputs
    task automatic check_comb(input int v);
        string       tag;
        logic [31:0] exp;
        tag = tag_name(v);
        exp = stim_word(v, 10);
        if (stall_o !== exp[0])
            report_mismatch(tag, "stall", 32'(exp[0]), 32'(stall_o));
        if (branch_enable_o !== exp[4])
            report_mismatch(tag, "branch_enable", 32'(exp[4]), 32'(branch_enable_o));
        if (next_in_delayslot_o !== exp[8])
            report_mismatch(tag, "next_in_delayslot", 32'(exp[8]), 32'(next_in_delayslot_o));
        if (branch_addr_o !== stim_word(v, 11))
            report_mismatch(tag, "branch_addr", stim_word(v, 11), branch_addr_o);
    endtask

    task automatic check_regs(input int v);
        string       tag;
        logic [31:0] ctl;
        logic [31:0] comb;
        logic [31:0] inst;
        logic [31:0] exp_pc;
        logic [15:0] exp_imm;
        tag  = tag_name(v);
        ctl  = stim_word(v, 12);
        comb = stim_word(v, 10);
        inst = stim_word(v, 2);
        // a stalled vector leaves a bubble with zero pc and immediate
        exp_pc  = comb[0] ? 32'h0 : stim_word(v, 1);
        exp_imm = comb[0] ? 16'h0 : inst[15:0];
        if (ex_pc_o !== exp_pc)
            report_mismatch(tag, "ex_pc", exp_pc, ex_pc_o);
        if (ex_aluop_o !== ctl[31:24])
            report_mismatch(tag, "ex_aluop", 32'(ctl[31:24]), 32'(ex_aluop_o));
        if (ex_wr_en_o !== ctl[20])
            report_mismatch(tag, "ex_wr_en", 32'(ctl[20]), 32'(ex_wr_en_o));
        if (ex_mem_to_reg_o !== ctl[16])
            report_mismatch(tag, "ex_mem_to_reg", 32'(ctl[16]), 32'(ex_mem_to_reg_o));
        if (ex_ram_we_o !== ctl[12])
            report_mismatch(tag, "ex_ram_we", 32'(ctl[12]), 32'(ex_ram_we_o));
        if (ex_in_delayslot_o !== ctl[8])
            report_mismatch(tag, "ex_in_delayslot", 32'(ctl[8]), 32'(ex_in_delayslot_o));
        if (ex_wr_addr_o !== ctl[4:0])
            report_mismatch(tag, "ex_wr_addr", 32'(ctl[4:0]), 32'(ex_wr_addr_o));
        if (ex_imm16_o !== exp_imm)
            report_mismatch(tag, "ex_imm16", 32'(exp_imm), 32'(ex_imm16_o));
        if (ex_link_addr_o !== stim_word(v, 13))
            report_mismatch(tag, "ex_link_addr", stim_word(v, 13), ex_link_addr_o);
        if (ex_rs_data_o !== rs_exp[v])
            report_mismatch(tag, "ex_rs_data", rs_exp[v], ex_rs_data_o);
        if (ex_rt_data_o !== rt_exp[v])
            report_mismatch(tag, "ex_rt_data", rt_exp[v], ex_rt_data_o);
    endtask

    task automatic run_vectors();
        for (int v = 0; v <= NUM_VEC; v++) begin
            @(posedge clk);
            if (v < NUM_VEC)
                drive_vector(v);
            else
                drive_idle();
            @(negedge clk);
            if (v < NUM_VEC)
                check_comb(v);
            // registers now hold the previous vector
            if (v > 0)
                check_regs(v - 1);
        end
    endtask

    initial begin
        clk                = 1'b0;
        reset_i            = 1'b0;
        pc_i               = '0;
        inst_i             = '0;
        rs_data_i          = '0;
        rt_data_i          = '0;
        ex_wr_en_i         = 1'b0;
        ex_wr_addr_i       = '0;
        ex_wr_data_i       = '0;
        ex_mem_to_reg_i    = 1'b0;
        mem_wr_en_i        = 1'b0;
        mem_wr_addr_i      = '0;
        mem_wr_data_i      = '0;
        now_in_delayslot_i = 1'b0;
        errors             = 0;
        void'($urandom(SEED));
        $readmemh("tests/id_stage_stim.txt", stim);
        stim_ok = !$isunknown(stim_word(NUM_VEC - 1, 0)) &&
                  (stim_word(NUM_VEC - 1, 0) != 32'h0);
        if (!stim_ok) begin
            errors++;
            $display("stimulus file is missing or holds fewer vectors than expected");
        end
        for (int r = 0; r < RESET_CYCLES; r++) begin
            @(posedge clk);
            if (r == RESET_CYCLES - 1)
                reset_i <= 1'b1;
            @(negedge clk);
            check_reset_state();
        end
        if (stim_ok)
            run_vectors();
        $display("vectors: %0d, errors: %0d", NUM_VEC, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- hw/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic [id_pkg::XLEN-1:0]   pc_i,
    input  logic [id_pkg::XLEN-1:0]   inst_i,
    input  logic [id_pkg::XLEN-1:0]   rs_data_i,
    input  logic [id_pkg::XLEN-1:0]   rt_data_i,
    input  logic                      ex_wr_en_i,
    input  logic [id_pkg::REG_AW-1:0] ex_wr_addr_i,
    input  logic [id_pkg::XLEN-1:0]   ex_wr_data_i,
    input  logic                      ex_mem_to_reg_i,
    input  logic                      mem_wr_en_i,
    input  logic [id_pkg::REG_AW-1:0] mem_wr_addr_i,
    input  logic [id_pkg::XLEN-1:0]   mem_wr_data_i,
    input  logic                      now_in_delayslot_i,
    output logic [id_pkg::XLEN-1:0]   ex_pc_o,
    output id_pkg::aluop_e            ex_aluop_o,
    output logic [id_pkg::XLEN-1:0]   ex_rs_data_o,
    output logic [id_pkg::XLEN-1:0]   ex_rt_data_o,
    output logic [id_pkg::IMM_W-1:0]  ex_imm16_o,
    output logic                      ex_wr_en_o,
    output logic [id_pkg::REG_AW-1:0] ex_wr_addr_o,
    output logic                      ex_mem_to_reg_o,
    output logic                      ex_ram_we_o,
    output logic [id_pkg::XLEN-1:0]   ex_link_addr_o,
    output logic                      ex_in_delayslot_o,
    output logic                      stall_o,
    output logic                      branch_enable_o,
    output logic [id_pkg::XLEN-1:0]   branch_addr_o,
    output logic                      next_in_delayslot_o
);

    logic                    rs_re;
    logic                    rt_re;
    logic [id_pkg::XLEN-1:0] rs_val;
    logic [id_pkg::XLEN-1:0] rt_val;
    logic [id_pkg::XLEN-1:0] link_addr;

    id_ctrl_if ctrl_if ();

    inst_decoder u_dec (
        .inst_i  (inst_i),
        .ctrl    (ctrl_if),
        .rs_re_o (rs_re),
        .rt_re_o (rt_re)
    );

    operand_select u_opsel (
        .inst_i          (inst_i),
        .rs_re_i         (rs_re),
        .rt_re_i         (rt_re),
        .rs_data_i       (rs_data_i),
        .rt_data_i       (rt_data_i),
        .ex_wr_en_i      (ex_wr_en_i),
        .ex_wr_addr_i    (ex_wr_addr_i),
        .ex_wr_data_i    (ex_wr_data_i),
        .ex_mem_to_reg_i (ex_mem_to_reg_i),
        .mem_wr_en_i     (mem_wr_en_i),
        .mem_wr_addr_i   (mem_wr_addr_i),
        .mem_wr_data_i   (mem_wr_data_i),
        .rs_val_o        (rs_val),
        .rt_val_o        (rt_val),
        .stall_o         (stall_o)
    );

    branch_unit u_br (
        .pc_i                (pc_i),
        .inst_i              (inst_i),
        .ctrl                (ctrl_if),
        .rs_val_i            (rs_val),
        .rt_val_i            (rt_val),
        .stall_i             (stall_o),
        .branch_enable_o     (branch_enable_o),
        .branch_addr_o       (branch_addr_o),
        .next_in_delayslot_o (next_in_delayslot_o),
        .link_addr_o         (link_addr)
    );

    id_ex_reg u_idex (
        .clk                (clk),
        .reset_i            (reset_i),
        .stall_i            (stall_o),
        .ctrl               (ctrl_if),
        .pc_i               (pc_i),
        .inst_i             (inst_i),
        .rs_val_i           (rs_val),
        .rt_val_i           (rt_val),
        .link_addr_i        (link_addr),
        .now_in_delayslot_i (now_in_delayslot_i),
        .ex_pc_o            (ex_pc_o),
        .ex_aluop_o         (ex_aluop_o),
        .ex_rs_data_o       (ex_rs_data_o),
        .ex_rt_data_o       (ex_rt_data_o),
        .ex_imm16_o         (ex_imm16_o),
        .ex_wr_en_o         (ex_wr_en_o),
        .ex_wr_addr_o       (ex_wr_addr_o),
        .ex_mem_to_reg_o    (ex_mem_to_reg_o),
        .ex_ram_we_o        (ex_ram_we_o),
        .ex_link_addr_o     (ex_link_addr_o),
        .ex_in_delayslot_o  (ex_in_delayslot_o)
    );

endmodule

//--- hw/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      stall_i,
    id_ctrl_if.regs                   ctrl,
    input  logic [id_pkg::XLEN-1:0]   pc_i,
    input  logic [id_pkg::XLEN-1:0]   inst_i,
    input  logic [id_pkg::XLEN-1:0]   rs_val_i,
    input  logic [id_pkg::XLEN-1:0]   rt_val_i,
    input  logic [id_pkg::XLEN-1:0]   link_addr_i,
    input  logic                      now_in_delayslot_i,
    output logic [id_pkg::XLEN-1:0]   ex_pc_o,
    output id_pkg::aluop_e            ex_aluop_o,
    output logic [id_pkg::XLEN-1:0]   ex_rs_data_o,
    output logic [id_pkg::XLEN-1:0]   ex_rt_data_o,
    output logic [id_pkg::IMM_W-1:0]  ex_imm16_o,
    output logic                      ex_wr_en_o,
    output logic [id_pkg::REG_AW-1:0] ex_wr_addr_o,
    output logic                      ex_mem_to_reg_o,
    output logic                      ex_ram_we_o,
    output logic [id_pkg::XLEN-1:0]   ex_link_addr_o,
    output logic                      ex_in_delayslot_o
);

    // bubble on reset and on load-use stall
    always_ff @(posedge clk) begin
        if (!reset_i || stall_i) begin
            ex_pc_o           <= '0;
            ex_aluop_o        <= id_pkg::ALU_NOP;
            ex_rs_data_o      <= '0;
            ex_rt_data_o      <= '0;
            ex_imm16_o        <= '0;
            ex_wr_en_o        <= 1'b0;
            ex_wr_addr_o      <= id_pkg::ZERO_REG;
            ex_mem_to_reg_o   <= 1'b0;
            ex_ram_we_o       <= 1'b0;
            ex_link_addr_o    <= '0;
            ex_in_delayslot_o <= 1'b0;
        end else begin
            ex_pc_o           <= pc_i;
            ex_aluop_o        <= ctrl.aluop;
            ex_rs_data_o      <= rs_val_i;
            ex_rt_data_o      <= rt_val_i;
            ex_imm16_o        <= inst_i[id_pkg::IMM_W-1:0];
            ex_wr_en_o        <= ctrl.wr_en;
            ex_wr_addr_o      <= ctrl.wr_addr;
            ex_mem_to_reg_o   <= ctrl.mem_to_reg;
            ex_ram_we_o       <= ctrl.ram_we;
            // EX selects this as the result of a linking instruction
            ex_link_addr_o    <= ctrl.link ? link_addr_i : '0;
            ex_in_delayslot_o <= now_in_delayslot_i;
        end
    end

endmodule

//--- hw/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic [id_pkg::XLEN-1:0] pc_i,
    input  logic [id_pkg::XLEN-1:0] inst_i,
    id_ctrl_if.br                   ctrl,
    input  logic [id_pkg::XLEN-1:0] rs_val_i,
    input  logic [id_pkg::XLEN-1:0] rt_val_i,
    input  logic                    stall_i,
    output logic                    branch_enable_o,
    output logic [id_pkg::XLEN-1:0] branch_addr_o,
    output logic                    next_in_delayslot_o,
    output logic [id_pkg::XLEN-1:0] link_addr_o
);

    logic [id_pkg::XLEN-1:0] pc_add4;
    logic [id_pkg::XLEN-1:0] pc_add8;
    logic [id_pkg::XLEN-1:0] rel_target;
    logic [id_pkg::XLEN-1:0] jmp_target;
    logic [id_pkg::XLEN-1:0] target;
    logic                    rs_zero;
    logic                    rs_neg;
    logic                    cond;

    assign pc_add4    = pc_i + id_pkg::XLEN'(4);
    assign pc_add8    = pc_i + id_pkg::XLEN'(8);
    assign rel_target = pc_add4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign jmp_target = {pc_add4[31:28], inst_i[25:0], 2'b00};
    assign rs_zero    = (rs_val_i == '0);
    assign rs_neg     = rs_val_i[id_pkg::XLEN-1];

    always_comb begin
        cond   = 1'b0;
        target = rel_target;
        case (ctrl.br_kind)
            id_pkg::BR_EQ:  cond = (rs_val_i == rt_val_i);
            id_pkg::BR_NE:  cond = (rs_val_i != rt_val_i);
            id_pkg::BR_GTZ: cond = !rs_neg && !rs_zero;
            id_pkg::BR_LEZ: cond = rs_neg || rs_zero;
            id_pkg::BR_GEZ: cond = !rs_neg;
            id_pkg::BR_LTZ: cond = rs_neg;
            id_pkg::BR_JUMP_IMM: begin
                cond   = 1'b1;
                target = jmp_target;
            end
            id_pkg::BR_JUMP_REG: begin
                cond   = 1'b1;
                target = rs_val_i;
            end
            default: ;
        endcase
    end

    // redirect waits until the operands are real
    assign branch_enable_o     = cond && !stall_i;
    assign branch_addr_o       = branch_enable_o ? target : '0;
    assign next_in_delayslot_o = (ctrl.br_kind != id_pkg::BR_NONE);
    assign link_addr_o         = ctrl.link ? pc_add8 : '0;

endmodule

//--- hw/operand_select.sv
`timescale 1ns/1ps

module operand_select (
    input  logic [id_pkg::XLEN-1:0]   inst_i,
    input  logic                      rs_re_i,
    input  logic                      rt_re_i,
    input  logic [id_pkg::XLEN-1:0]   rs_data_i,
    input  logic [id_pkg::XLEN-1:0]   rt_data_i,
    input  logic                      ex_wr_en_i,
    input  logic [id_pkg::REG_AW-1:0] ex_wr_addr_i,
    input  logic [id_pkg::XLEN-1:0]   ex_wr_data_i,
    input  logic                      ex_mem_to_reg_i,
    input  logic                      mem_wr_en_i,
    input  logic [id_pkg::REG_AW-1:0] mem_wr_addr_i,
    input  logic [id_pkg::XLEN-1:0]   mem_wr_data_i,
    output logic [id_pkg::XLEN-1:0]   rs_val_o,
    output logic [id_pkg::XLEN-1:0]   rt_val_o,
    output logic                      stall_o
);

    logic [id_pkg::REG_AW-1:0] rs;
    logic [id_pkg::REG_AW-1:0] rt;

    assign rs = inst_i[25:21];
    assign rt = inst_i[20:16];

    // EX data beats MEM data and an unread source is zero
    function automatic logic [id_pkg::XLEN-1:0] fwd(
        input logic                      re,
        input logic [id_pkg::REG_AW-1:0] src,
        input logic [id_pkg::XLEN-1:0]   rf_data
    );
        if (!re)
            return '0;
        if (ex_wr_en_i && ex_wr_addr_i == src)
            return ex_wr_data_i;
        if (mem_wr_en_i && mem_wr_addr_i == src)
            return mem_wr_data_i;
        return rf_data;
    endfunction

    always_comb begin
        rs_val_o = fwd(rs_re_i, rs, rs_data_i);
        rt_val_o = fwd(rt_re_i, rt, rt_data_i);
    end

    // load in EX cannot be forwarded yet
    assign stall_o = ex_mem_to_reg_i &&
                     ((rs_re_i && ex_wr_addr_i == rs) || (rt_re_i && ex_wr_addr_i == rt));

endmodule

//--- hw/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [id_pkg::XLEN-1:0] inst_i,
    id_ctrl_if.dec                  ctrl,
    output logic                    rs_re_o,
    output logic                    rt_re_o
);

    id_pkg::opcode_e           op;
    id_pkg::funct_e            fn;
    id_pkg::regimm_e           ri;
    logic [id_pkg::REG_AW-1:0] rs;
    logic [id_pkg::REG_AW-1:0] rt;
    logic [id_pkg::REG_AW-1:0] rd;
    id_pkg::aluop_e            aluop;

    assign op = id_pkg::opcode_e'(inst_i[31:26]);
    assign fn = id_pkg::funct_e'(inst_i[5:0]);
    assign ri = id_pkg::regimm_e'(inst_i[20:16]);
    assign rs = inst_i[25:21];
    assign rt = inst_i[20:16];
    assign rd = inst_i[15:11];

    // ####################
    // opcode to operation
    // ####################
    always_comb begin
        aluop = id_pkg::ALU_NOP;
        case (op)
            id_pkg::OP_SPECIAL: begin
                case (fn)
                    id_pkg::FN_AND:  aluop = id_pkg::ALU_AND;
                    id_pkg::FN_OR:   aluop = id_pkg::ALU_OR;
                    id_pkg::FN_XOR:  aluop = id_pkg::ALU_XOR;
                    id_pkg::FN_NOR:  aluop = id_pkg::ALU_NOR;
                    id_pkg::FN_ADD:  aluop = id_pkg::ALU_ADD;
                    id_pkg::FN_ADDU: aluop = id_pkg::ALU_ADDU;
                    id_pkg::FN_SUB:  aluop = id_pkg::ALU_SUB;
                    id_pkg::FN_SUBU: aluop = id_pkg::ALU_SUBU;
                    id_pkg::FN_SLT:  aluop = id_pkg::ALU_SLT;
                    id_pkg::FN_SLTU: aluop = id_pkg::ALU_SLTU;
                    id_pkg::FN_SLLV: aluop = id_pkg::ALU_SLLV;
                    id_pkg::FN_SRLV: aluop = id_pkg::ALU_SRLV;
                    id_pkg::FN_SRAV: aluop = id_pkg::ALU_SRAV;
                    // immediate shifts need rs field zero
                    id_pkg::FN_SLL:  if (rs == id_pkg::ZERO_REG) aluop = id_pkg::ALU_SLL;
                    id_pkg::FN_SRL:  if (rs == id_pkg::ZERO_REG) aluop = id_pkg::ALU_SRL;
                    id_pkg::FN_SRA:  if (rs == id_pkg::ZERO_REG) aluop = id_pkg::ALU_SRA;
                    id_pkg::FN_JR: begin
                        if (rt == id_pkg::ZERO_REG && rd == id_pkg::ZERO_REG)
                            aluop = id_pkg::ALU_JR;
                    end
                    id_pkg::FN_JALR: if (rt == id_pkg::ZERO_REG) aluop = id_pkg::ALU_JALR;
                    default: ;
                endcase
            end
            id_pkg::OP_REGIMM: begin
                case (ri)
                    id_pkg::RI_BLTZ:   aluop = id_pkg::ALU_BLTZ;
                    id_pkg::RI_BGEZ:   aluop = id_pkg::ALU_BGEZ;
                    id_pkg::RI_BLTZAL: aluop = id_pkg::ALU_BLTZAL;
                    id_pkg::RI_BGEZAL: aluop = id_pkg::ALU_BGEZAL;
                    default: ;
                endcase
            end
            id_pkg::OP_J:     aluop = id_pkg::ALU_J;
            id_pkg::OP_JAL:   aluop = id_pkg::ALU_JAL;
            id_pkg::OP_BEQ:   aluop = id_pkg::ALU_BEQ;
            id_pkg::OP_BNE:   aluop = id_pkg::ALU_BNE;
            id_pkg::OP_BLEZ:  aluop = id_pkg::ALU_BLEZ;
            id_pkg::OP_BGTZ:  aluop = id_pkg::ALU_BGTZ;
            id_pkg::OP_ADDI:  aluop = id_pkg::ALU_ADDI;
            id_pkg::OP_ADDIU: aluop = id_pkg::ALU_ADDIU;
            id_pkg::OP_SLTI:  aluop = id_pkg::ALU_SLTI;
            id_pkg::OP_SLTIU: aluop = id_pkg::ALU_SLTIU;
            id_pkg::OP_ANDI:  aluop = id_pkg::ALU_ANDI;
            id_pkg::OP_ORI:   aluop = id_pkg::ALU_ORI;
            id_pkg::OP_XORI:  aluop = id_pkg::ALU_XORI;
            id_pkg::OP_LUI:   aluop = id_pkg::ALU_LUI;
            id_pkg::OP_LW:    aluop = id_pkg::ALU_LW;
            id_pkg::OP_SW:    aluop = id_pkg::ALU_SW;
            default: ;
        endcase
    end

    // ####################
    // operation to control
    // ####################
    always_comb begin
        ctrl.aluop      = aluop;
        ctrl.wr_en      = 1'b0;
        ctrl.wr_addr    = id_pkg::ZERO_REG;
        ctrl.mem_to_reg = 1'b0;
        ctrl.ram_we     = 1'b0;
        ctrl.link       = 1'b0;
        ctrl.br_kind    = id_pkg::BR_NONE;
        rs_re_o         = 1'b0;
        rt_re_o         = 1'b0;
        case (aluop)
            id_pkg::ALU_AND, id_pkg::ALU_OR, id_pkg::ALU_XOR, id_pkg::ALU_NOR,
            id_pkg::ALU_ADD, id_pkg::ALU_ADDU, id_pkg::ALU_SUB, id_pkg::ALU_SUBU,
            id_pkg::ALU_SLT, id_pkg::ALU_SLTU, id_pkg::ALU_SLLV, id_pkg::ALU_SRLV,
            id_pkg::ALU_SRAV: begin
                ctrl.wr_en   = 1'b1;
                ctrl.wr_addr = rd;
                rs_re_o      = 1'b1;
                rt_re_o      = 1'b1;
            end
            id_pkg::ALU_SLL, id_pkg::ALU_SRL, id_pkg::ALU_SRA: begin
                ctrl.wr_en   = 1'b1;
                ctrl.wr_addr = rd;
                rt_re_o      = 1'b1;
            end
            id_pkg::ALU_ANDI, id_pkg::ALU_ORI, id_pkg::ALU_XORI, id_pkg::ALU_ADDI,
            id_pkg::ALU_ADDIU, id_pkg::ALU_SLTI, id_pkg::ALU_SLTIU, id_pkg::ALU_LW: begin
                ctrl.wr_en      = 1'b1;
                ctrl.wr_addr    = rt;
                ctrl.mem_to_reg = (aluop == id_pkg::ALU_LW);
                rs_re_o         = 1'b1;
            end
            id_pkg::ALU_LUI: begin
                ctrl.wr_en   = 1'b1;
                ctrl.wr_addr = rt;
            end
            id_pkg::ALU_SW: begin
                ctrl.ram_we = 1'b1;
                rs_re_o     = 1'b1;
                rt_re_o     = 1'b1;
            end
            id_pkg::ALU_BEQ, id_pkg::ALU_BNE: begin
                ctrl.br_kind = (aluop == id_pkg::ALU_BEQ) ? id_pkg::BR_EQ : id_pkg::BR_NE;
                rs_re_o      = 1'b1;
                rt_re_o      = 1'b1;
            end
            id_pkg::ALU_BGTZ: begin
                ctrl.br_kind = id_pkg::BR_GTZ;
                rs_re_o      = 1'b1;
            end
            id_pkg::ALU_BLEZ: begin
                ctrl.br_kind = id_pkg::BR_LEZ;
                rs_re_o      = 1'b1;
            end
            id_pkg::ALU_BGEZ, id_pkg::ALU_BGEZAL: begin
                ctrl.br_kind = id_pkg::BR_GEZ;
                rs_re_o      = 1'b1;
            end
            id_pkg::ALU_BLTZ, id_pkg::ALU_BLTZAL: begin
                ctrl.br_kind = id_pkg::BR_LTZ;
                rs_re_o      = 1'b1;
            end
            id_pkg::ALU_J, id_pkg::ALU_JAL: ctrl.br_kind = id_pkg::BR_JUMP_IMM;
            id_pkg::ALU_JR, id_pkg::ALU_JALR: begin
                ctrl.br_kind = id_pkg::BR_JUMP_REG;
                rs_re_o      = 1'b1;
            end
            default: ;
        endcase

        // linking forms write the return address to register 31 or to jalr's rd
        if (aluop == id_pkg::ALU_JAL || aluop == id_pkg::ALU_BGEZAL ||
            aluop == id_pkg::ALU_BLTZAL || aluop == id_pkg::ALU_JALR) begin
            ctrl.link    = 1'b1;
            ctrl.wr_en   = 1'b1;
            ctrl.wr_addr = (aluop == id_pkg::ALU_JALR) ? rd : id_pkg::LINK_REG;
        end
    end

endmodule

//--- hw/id_ctrl_if.sv
`timescale 1ns/1ps

// decoded control from the decoder to the branch unit and ID/EX register
interface id_ctrl_if;
    id_pkg::aluop_e                 aluop;
    logic                           wr_en;
    logic [id_pkg::REG_AW-1:0]      wr_addr;
    logic                           mem_to_reg;
    logic                           ram_we;
    logic                           link;
    id_pkg::br_kind_e               br_kind;

    modport dec (
        output aluop, wr_en, wr_addr, mem_to_reg, ram_we, link, br_kind
    );
    modport br (
        input br_kind, link
    );
    // ID/EX register side
    modport regs (
        input aluop, wr_en, wr_addr, mem_to_reg, ram_we, link
    );
endinterface

//--- hw/id_pkg.sv
package id_pkg;

    // ####################
    // widths and registers
    // ####################
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int IMM_W  = 16;

    localparam logic [REG_AW-1:0] LINK_REG = 5'd31;
    localparam logic [REG_AW-1:0] ZERO_REG = 5'd0;

    // ####################
    // instruction fields
    // ####################
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
        OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
        OP_LW      = 6'h23, OP_SW     = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03, FN_SLLV = 6'h04,
        FN_SRLV = 6'h06, FN_SRAV = 6'h07, FN_JR   = 6'h08, FN_JALR = 6'h09,
        FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB  = 6'h22, FN_SUBU = 6'h23,
        FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR  = 6'h26, FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
    } funct_e;

    // rt field under REGIMM
    typedef enum logic [4:0] {
        RI_BLTZ = 5'h00, RI_BGEZ = 5'h01, RI_BLTZAL = 5'h10, RI_BGEZAL = 5'h11
    } regimm_e;

    // ####################
    // operations for EX
    // ####################
    typedef enum logic [7:0] {
        ALU_NOP   = 8'h00, ALU_AND    = 8'h01, ALU_OR     = 8'h02, ALU_XOR   = 8'h03,
        ALU_NOR   = 8'h04, ALU_ADD    = 8'h05, ALU_ADDU   = 8'h06, ALU_SUB   = 8'h07,
        ALU_SUBU  = 8'h08, ALU_SLT    = 8'h09, ALU_SLTU   = 8'h0a, ALU_SLL   = 8'h0b,
        ALU_SRL   = 8'h0c, ALU_SRA    = 8'h0d, ALU_SLLV   = 8'h0e, ALU_SRLV  = 8'h0f,
        ALU_SRAV  = 8'h10, ALU_ANDI   = 8'h11, ALU_ORI    = 8'h12, ALU_XORI  = 8'h13,
        ALU_ADDI  = 8'h14, ALU_ADDIU  = 8'h15, ALU_SLTI   = 8'h16, ALU_SLTIU = 8'h17,
        ALU_LUI   = 8'h18, ALU_LW     = 8'h19, ALU_SW     = 8'h1a, ALU_BEQ   = 8'h1b,
        ALU_BNE   = 8'h1c, ALU_BGTZ   = 8'h1d, ALU_BLEZ   = 8'h1e, ALU_BGEZ  = 8'h1f,
        ALU_BLTZ  = 8'h20, ALU_BGEZAL = 8'h21, ALU_BLTZAL = 8'h22, ALU_J     = 8'h23,
        ALU_JAL   = 8'h24, ALU_JR     = 8'h25, ALU_JALR   = 8'h26
    } aluop_e;

    typedef enum logic [3:0] {
        BR_NONE     = 4'h0,
        BR_EQ       = 4'h1,
        BR_NE       = 4'h2,
        BR_GTZ      = 4'h3,
        BR_LEZ      = 4'h4,
        BR_GEZ      = 4'h5,
        BR_LTZ      = 4'h6,
        BR_JUMP_IMM = 4'h7,
        BR_JUMP_REG = 4'h8
    } br_kind_e;

endpackage
